// File: source/norm_check_pkg.sv
// ML-DSA-87 norm check constants, mode and state types, and the bound lookup
`default_nettype none

package norm_check_pkg;

    // Ring and vector dimensions for ML-DSA-87
    localparam logic [31:0] mldsa_q = 32'd8380417;
    localparam int mldsa_n = 256;
    localparam int mldsa_l = 7;
    localparam int mldsa_k = 8;

    // Rounding and rejection parameters
    localparam logic [31:0] mldsa_gamma1 = 32'd524288;
    localparam logic [31:0] mldsa_beta = 32'd120;
    localparam logic [31:0] mldsa_gamma2 = (mldsa_q - 32'd1) / 32'd32;

    // Memory geometry
    localparam int coeff_width = 23;
    localparam int coeffs_per_word = 4;
    localparam int mem_data_width = coeff_width * coeffs_per_word;
    localparam int mem_addr_width = 9;
    localparam int words_per_poly = mldsa_n / coeffs_per_word;
    // Two words per read cycle
    localparam int beat_per_poly = words_per_poly / 2;

    // APB register map
    localparam int apb_addr_width = 4;
    localparam logic [apb_addr_width-1:0] reg_ctrl = 4'h0;
    localparam logic [apb_addr_width-1:0] reg_base = 4'h4;
    localparam logic [apb_addr_width-1:0] reg_status = 4'h8;

    // Check modes, value 3 is reserved
    typedef enum logic [1:0] {
        z_bound   = 2'd0,
        r0_bound  = 2'd1,
        ct0_bound = 2'd2,
        mode_rsvd = 2'd3
    } chk_norm_mode_t;

    // Read sequencer states
    typedef enum logic [1:0] {
        CHK_IDLE   = 2'd0,
        CHK_RD_MEM = 2'd1,
        CHK_DONE   = 2'd2
    } chk_read_state_e;

    // Bound B per mode, a coefficient fails when its centered magnitude reaches B
    function automatic logic [31:0] norm_bound(input chk_norm_mode_t mode);
        case (mode)
            z_bound:   return mldsa_gamma1 - mldsa_beta;
            r0_bound:  return mldsa_gamma2 - mldsa_beta;
            ct0_bound: return mldsa_gamma2;
            // Never written by software
            default:   return mldsa_gamma2;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: source/coeff_rd_if.sv
// Dual-port coefficient read path between the check controller and the memory
`timescale 1ns/100ps
`default_nettype none

interface coeff_rd_if;
    import norm_check_pkg::*;

    // One read strobe shared by both ports
    logic rd_en;
    // Even port walks words 0, 2, 4 and so on
    logic [mem_addr_width-1:0] addr_even;
    // Odd port walks words 1, 3, 5 and so on
    logic [mem_addr_width-1:0] addr_odd;
    // Registered read data, valid one cycle after rd_en
    logic [mem_data_width-1:0] rdata_even;
    logic [mem_data_width-1:0] rdata_odd;

    // Controller side issues the requests
    modport ctrl (
        output rd_en,
        output addr_even,
        output addr_odd
    );

    // Memory side returns the data
    modport mem (
        input  rd_en,
        input  addr_even,
        input  addr_odd,
        output rdata_even,
        output rdata_odd
    );

endinterface

`default_nettype wire

// File: source/norm_check_ctrl.sv
// Read sequencer that walks every polynomial of the selected vector, two words per cycle
`timescale 1ns/100ps
`default_nettype none

module norm_check_ctrl (
    input  logic                                         clk,
    input  logic                                         reset_n,
    input  logic                                         zeroize,
    input  logic                                         start,
    input  norm_check_pkg::chk_norm_mode_t               mode,
    input  logic [norm_check_pkg::mem_addr_width-1:0]    base_addr,
    coeff_rd_if.ctrl                                     rd,
    output logic                                         check_enable,
    output logic                                         frame_done,
    output logic                                         busy
);
    import norm_check_pkg::*;

    chk_read_state_e state, state_nxt;
    // Word-pair index, 32 pairs per polynomial
    logic [mem_addr_width-2:0] pair_cnt;
    logic [mem_addr_width-1:0] even_addr;
    logic [mem_addr_width-1:0] last_pair;
    logic [3:0] num_poly;
    logic last_beat;

    // Polynomial count per mode
    always_comb begin
        case (mode)
            z_bound:   num_poly = 4'(mldsa_l);
            r0_bound:  num_poly = 4'(mldsa_k);
            ct0_bound: num_poly = 4'(mldsa_k);
            mode_rsvd: num_poly = 4'(mldsa_k);
            default:   num_poly = 4'(mldsa_k);
        endcase
    end

    // Last pair index is 32*P - 1
    always_comb begin
        last_pair = mem_addr_width'(int'(num_poly) * beat_per_poly - 1);
        last_beat = ({1'b0, pair_cnt} == last_pair);
    end

    // Pair counter, loaded on start from idle only
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pair_cnt <= '0;
        end else if (zeroize) begin
            pair_cnt <= '0;
        end else if (state == CHK_IDLE && start) begin
            pair_cnt <= '0;
        end else if (state == CHK_RD_MEM) begin
            pair_cnt <= pair_cnt + 1'b1;
        end
    end

    // Base plus twice the pair index, wraps modulo 512
    always_comb begin
        even_addr = base_addr + {pair_cnt, 1'b0};
        rd.addr_even = even_addr;
        rd.addr_odd = even_addr + 1'b1;
        rd.rd_en = (state == CHK_RD_MEM);
    end

    // State register
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= CHK_IDLE;
        end else if (zeroize) begin
            state <= CHK_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Next state, start while busy falls through unseen
    always_comb begin
        state_nxt = state;
        case (state)
            CHK_IDLE:   state_nxt = start ? CHK_RD_MEM : CHK_IDLE;
            CHK_RD_MEM: state_nxt = last_beat ? CHK_DONE : CHK_RD_MEM;
            CHK_DONE:   state_nxt = CHK_IDLE;
            default:    state_nxt = CHK_IDLE;
        endcase
    end

    // Framing toward the check unit
    always_comb begin
        check_enable = (state == CHK_RD_MEM);
        frame_done = (state == CHK_DONE);
        busy = (state != CHK_IDLE);
    end

    // Reads never run past the last pair of the vector
    a_rd_only_in_read: assert property (@(posedge clk) disable iff (!reset_n)
        rd.rd_en |-> {1'b0, pair_cnt} <= last_pair);

    // Frame end is a single-cycle strobe
    a_frame_done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        frame_done |=> !frame_done);

endmodule

`default_nettype wire

// File: source/norm_check_unit.sv
// Eight parallel centered-range coefficient checks with a sticky violation flag
`timescale 1ns/100ps
`default_nettype none

module norm_check_unit (
    input  logic                                      clk,
    input  logic                                      reset_n,
    input  logic                                      zeroize,
    input  norm_check_pkg::chk_norm_mode_t            mode,
    input  logic                                      check_enable,
    input  logic                                      frame_done,
    input  logic [norm_check_pkg::mem_data_width-1:0] rdata_even,
    input  logic [norm_check_pkg::mem_data_width-1:0] rdata_odd,
    output logic                                      result_valid,
    output logic                                      violation
);
    import norm_check_pkg::*;

    // Enable lined up with the registered read data
    logic chk_en_d;
    logic [2*mem_data_width-1:0] beat_data;
    logic [2*coeffs_per_word-1:0] coeff_hit;
    logic [31:0] bound;
    logic [31:0] upper;

    // Even word holds the lower four coefficients of the beat
    assign beat_data = {rdata_odd, rdata_even};

    // Violation window is [B, q-B], plus anything at or above q
    always_comb begin
        logic [31:0] coeff;
        bound = norm_bound(mode);
        upper = mldsa_q - bound;
        coeff = '0;
        for (int i = 0; i < 2 * coeffs_per_word; i++) begin
            coeff = 32'(beat_data[i*coeff_width +: coeff_width]);
            coeff_hit[i] = ((coeff >= bound) && (coeff <= upper)) || (coeff >= mldsa_q);
        end
    end

    // One-cycle delay of the framing strobes
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            chk_en_d <= 1'b0;
            result_valid <= 1'b0;
        end else if (zeroize) begin
            chk_en_d <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            chk_en_d <= check_enable;
            // Last beat was folded in on the frame_done edge
            result_valid <= frame_done;
        end
    end

    // Sticky flag
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            violation <= 1'b0;
        end else if (zeroize) begin
            violation <= 1'b0;
        end else if (check_enable && !chk_en_d) begin
            // First read cycle of a frame, data not yet back
            violation <= 1'b0;
        end else if (chk_en_d) begin
            violation <= violation | (|coeff_hit);
        end
    end

endmodule

`default_nettype wire

// File: source/coeff_mem.sv
// Coefficient store with one write port and two registered read ports
`timescale 1ns/100ps
`default_nettype none

module coeff_mem (
    input  logic                                      clk,
    input  logic                                      wr_en,
    input  logic [norm_check_pkg::mem_addr_width-1:0] wr_addr,
    input  logic [norm_check_pkg::mem_data_width-1:0] wr_data,
    coeff_rd_if.mem                                   rd
);
    import norm_check_pkg::*;

    // 512 words of four packed coefficients
    logic [mem_data_width-1:0] mem [2**mem_addr_width];

    // Load port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Both read ports update together on a read cycle
    always_ff @(posedge clk) begin
        if (rd.rd_en) begin
            rd.rdata_even <= mem[rd.addr_even];
            rd.rdata_odd <= mem[rd.addr_odd];
        end
    end

    // Controller must never aim both ports at one word
    a_ports_distinct: assert property (@(posedge clk)
        rd.rd_en |-> rd.addr_even != rd.addr_odd);

endmodule

`default_nettype wire

// File: source/norm_check_apb_regs.sv
// APB register file with control, base address and status for the norm check
`timescale 1ns/100ps
`default_nettype none

module norm_check_apb_regs (
    input  logic                                      clk,
    input  logic                                      reset_n,
    input  logic                                      psel,
    input  logic                                      penable,
    input  logic                                      pwrite,
    input  logic [norm_check_pkg::apb_addr_width-1:0] paddr,
    input  logic [31:0]                               pwdata,
    output logic [31:0]                               prdata,
    output logic                                      pready,
    output logic                                      pslverr,
    output logic                                      start,
    output logic                                      zeroize,
    output norm_check_pkg::chk_norm_mode_t            mode,
    output logic [norm_check_pkg::mem_addr_width-1:0] base_addr,
    input  logic                                      busy,
    input  logic                                      result_valid,
    input  logic                                      violation
);
    import norm_check_pkg::*;

    logic access;
    logic hit_ctrl;
    logic hit_base;
    logic hit_status;
    logic mode_bad;
    logic ctrl_wr;
    logic done_q;
    logic violation_q;

    // Address decode and error response, all in the access phase
    always_comb begin
        access = psel && penable;
        hit_ctrl = (paddr == reg_ctrl);
        hit_base = (paddr == reg_base);
        hit_status = (paddr == reg_status);
        mode_bad = pwrite && hit_ctrl && (pwdata[3:2] == mode_rsvd);
        ctrl_wr = access && pwrite && hit_ctrl && !mode_bad;
        pready = 1'b1;
        pslverr = access && (!(hit_ctrl || hit_base || hit_status) || mode_bad);
    end

    // Control and base registers, start and zeroize self-clear
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            start <= 1'b0;
            zeroize <= 1'b0;
            mode <= z_bound;
            base_addr <= '0;
        end else begin
            start <= 1'b0;
            zeroize <= 1'b0;
            if (ctrl_wr) begin
                start <= pwdata[0];
                zeroize <= pwdata[1];
                mode <= chk_norm_mode_t'(pwdata[3:2]);
            end
            if (access && pwrite && hit_base) begin
                base_addr <= pwdata[mem_addr_width-1:0];
            end
        end
    end

    // Status, done held until the next start or zeroize
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            done_q <= 1'b0;
            violation_q <= 1'b0;
        end else if (start || zeroize) begin
            done_q <= 1'b0;
            violation_q <= 1'b0;
        end else if (result_valid) begin
            done_q <= 1'b1;
            violation_q <= violation;
        end
    end

    // Read mux
    always_comb begin
        prdata = '0;
        if (hit_ctrl) begin
            prdata[3:2] = mode;
        end else if (hit_base) begin
            prdata[mem_addr_width-1:0] = base_addr;
        end else if (hit_status) begin
            prdata[2:0] = {violation_q, done_q, busy};
        end
    end

endmodule

`default_nettype wire

// File: source/norm_check_top.sv
// Norm check subsystem top with APB registers, sequencer, coefficient memory and checker
`timescale 1ns/100ps
`default_nettype none

module norm_check_top (
    input  logic                                      clk,
    input  logic                                      reset_n,
    input  logic                                      psel,
    input  logic                                      penable,
    input  logic                                      pwrite,
    input  logic [norm_check_pkg::apb_addr_width-1:0] paddr,
    input  logic [31:0]                               pwdata,
    output logic [31:0]                               prdata,
    output logic                                      pready,
    output logic                                      pslverr,
    input  logic                                      mem_wr_en,
    input  logic [norm_check_pkg::mem_addr_width-1:0] mem_wr_addr,
    input  logic [norm_check_pkg::mem_data_width-1:0] mem_wr_data
);
    import norm_check_pkg::*;

    logic start;
    logic zeroize;
    chk_norm_mode_t mode;
    logic [mem_addr_width-1:0] base_addr;
    logic busy;
    logic check_enable;
    logic frame_done;
    logic result_valid;
    logic violation;

    // Read path between sequencer and memory
    coeff_rd_if rd_if ();

    norm_check_apb_regs u_regs (
        .clk          (clk),
        .reset_n      (reset_n),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .start        (start),
        .zeroize      (zeroize),
        .mode         (mode),
        .base_addr    (base_addr),
        .busy         (busy),
        .result_valid (result_valid),
        .violation    (violation)
    );

    norm_check_ctrl u_ctrl (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize      (zeroize),
        .start        (start),
        .mode         (mode),
        .base_addr    (base_addr),
        .rd           (rd_if.ctrl),
        .check_enable (check_enable),
        .frame_done   (frame_done),
        .busy         (busy)
    );

    coeff_mem u_mem (
        .clk     (clk),
        .wr_en   (mem_wr_en),
        .wr_addr (mem_wr_addr),
        .wr_data (mem_wr_data),
        .rd      (rd_if.mem)
    );

    norm_check_unit u_unit (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize      (zeroize),
        .mode         (mode),
        .check_enable (check_enable),
        .frame_done   (frame_done),
        .rdata_even   (rd_if.rdata_even),
        .rdata_odd    (rd_if.rdata_odd),
        .result_valid (result_valid),
        .violation    (violation)
    );

endmodule

`default_nettype wire

// File: tb/tb_norm_check.sv
// Self-checking testbench for the ML-DSA norm check subsystem, driven from a stimulus file
`timescale 1ns/100ps
`default_nettype none

module tb_norm_check;
    import norm_check_pkg::*;

    // Reference parameters of ML-DSA-87
    localparam logic [31:0] ref_q = 32'd8380417;
    localparam logic [31:0] ref_gamma1 = 32'd1 << 19;
    localparam logic [31:0] ref_beta = 32'd120;
    localparam logic [31:0] ref_gamma2 = (ref_q - 32'd1) / 32'd32;
    localparam int max_status_polls = 400;
    localparam int max_ready_polls = 16;

    logic clk;
    logic reset_n;
    logic psel;
    logic penable;
    logic pwrite;
    logic [apb_addr_width-1:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic mem_wr_en;
    logic [mem_addr_width-1:0] mem_wr_addr;
    logic [mem_data_width-1:0] mem_wr_data;

    int value_errs;
    int other_errs;

    norm_check_top u_dut (
        .clk         (clk),
        .reset_n     (reset_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data)
    );

    // 4 ns clock
    always #2 clk = ~clk;

    // Bound B per mode
    function automatic logic [31:0] bound_for_mode(input int mode);
        case (mode)
            0:       return ref_gamma1 - ref_beta;
            1:       return ref_gamma2 - ref_beta;
            default: return ref_gamma2;
        endcase
    endfunction

    // Fails when inside [B, q-B] or not reduced mod q
    function automatic logic is_violation(input logic [31:0] c, input logic [31:0] b);
        return ((c >= b) && (c <= ref_q - b)) || (c >= ref_q);
    endfunction

    // Random coefficient with centered magnitude below B
    function automatic logic [coeff_width-1:0] random_inside(input logic [31:0] b);
        logic [31:0] r;
        r = $urandom % (2 * b - 1);
        if (r < b) begin
            return r[coeff_width-1:0];
        end
        return coeff_width'(ref_q - (r - b + 1));
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            value_errs++;
            $display("[FAIL] %s expected 0x%0h got 0x%0h", name, expected, actual);
        end
    endtask

    // One APB transfer, sampled mid-cycle in the access phase
    task automatic apb_xfer(input logic wr, input logic [apb_addr_width-1:0] addr,
                            input logic [31:0] data, output logic [31:0] rdata,
                            output logic err);
        int polls;
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= wr;
        paddr <= addr;
        pwdata <= data;
        @(posedge clk);
        penable <= 1'b1;
        polls = 0;
        @(negedge clk);
        while (!pready && polls < max_ready_polls) begin
            @(negedge clk);
            polls++;
        end
        if (!pready) begin
            other_errs++;
            $display("APB transfer to offset 0x%0h never completed", addr);
        end
        rdata = prdata;
        err = pslverr;
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    // Poll status until done is set
    task automatic wait_done(output logic [31:0] status);
        logic err;
        int polls;
        polls = 0;
        apb_xfer(1'b0, reg_status, 32'd0, status, err);
        while (!status[1] && polls < max_status_polls) begin
            apb_xfer(1'b0, reg_status, 32'd0, status, err);
            polls++;
        end
        if (!status[1]) begin
            other_errs++;
            $display("Check never finished within %0d status reads", max_status_polls);
        end
    endtask

    // Fill all 512 words from base upward, with at most one injected coefficient
    task automatic fill_memory(input int mode, input int base, input int idx,
                               input logic [31:0] val);
        logic [mem_data_width-1:0] word;
        logic [31:0] b;
        b = bound_for_mode(mode);
        for (int w = 0; w < 2 ** mem_addr_width; w++) begin
            for (int j = 0; j < coeffs_per_word; j++) begin
                if (w * coeffs_per_word + j == idx) begin
                    word[j*coeff_width +: coeff_width] = val[coeff_width-1:0];
                end else begin
                    word[j*coeff_width +: coeff_width] = random_inside(b);
                end
            end
            @(posedge clk);
            mem_wr_en <= 1'b1;
            mem_wr_addr <= mem_addr_width'(base + w);
            mem_wr_data <= word;
        end
        @(posedge clk);
        mem_wr_en <= 1'b0;
    endtask

    // Load, start, wait and compare the verdict
    task automatic run_case(input int case_no, input int mode, input int base, input int idx,
                            input logic [31:0] val, input int file_exp);
        logic [31:0] rdata;
        logic [31:0] status;
        logic err;
        int polys;
        int calc;
        polys = (mode == 0) ? mldsa_l : mldsa_k;
        calc = 0;
        // Only coefficients inside the selected vector count
        if (idx >= 0 && idx < polys * mldsa_n && is_violation(val, bound_for_mode(mode))) begin
            calc = 1;
        end
        assert (calc == file_exp) else begin
            other_errs++;
            $display("Case %0d: file verdict %0d disagrees with rule verdict %0d",
                     case_no, file_exp, calc);
        end
        apb_xfer(1'b1, reg_base, 32'(base), rdata, err);
        fill_memory(mode, base, idx, val);
        apb_xfer(1'b1, reg_ctrl, 32'((mode << 2) | 1), rdata, err);
        wait_done(status);
        // Expect done set, busy clear
        check_value($sformatf("status (case %0d)", case_no), {29'd0, calc[0], 2'b10}, status);
    endtask

    initial begin
        int fd;
        int fields;
        int case_no;
        int mode_i;
        int base_i;
        int idx_i;
        int exp_i;
        logic [31:0] val;
        logic [31:0] rdata;
        logic [31:0] ctrl_before;
        logic [31:0] status_before;
        logic err;
        string line;
        void'($urandom(76));
        clk = 1'b0;
        reset_n = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        mem_wr_en = 1'b0;
        mem_wr_addr = '0;
        mem_wr_data = '0;
        value_errs = 0;
        other_errs = 0;
        case_no = 0;
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;

        // Clean state after reset
        apb_xfer(1'b0, reg_status, 32'd0, rdata, err);
        check_value("status", 32'd0, rdata);
        check_value("pslverr", 32'd0, 32'(err));

        // Cases from the stimulus file
        fd = $fopen("tb/norm_check_input.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("Cannot open the stimulus file");
        end else begin
            while (!$feof(fd)) begin
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#") begin
                    fields = $sscanf(line, "%d %h %d %h %d", mode_i, base_i, idx_i, val, exp_i);
                    if (fields == 5) begin
                        case_no++;
                        run_case(case_no, mode_i, base_i, idx_i, val, exp_i);
                    end
                end
            end
            $fclose(fd);
        end

        // Zeroize on an idle block clears a latched failing verdict
        run_case(case_no + 1, 1, 0, 0, ref_gamma2 - ref_beta, 1);
        apb_xfer(1'b1, reg_ctrl, 32'h6, rdata, err);
        apb_xfer(1'b0, reg_status, 32'd0, rdata, err);
        check_value("status after idle zeroize", 32'd0, rdata);

        // Zeroize in the middle of an r0_bound check
        fill_memory(1, 0, -1, 32'd0);
        apb_xfer(1'b1, reg_ctrl, 32'h5, rdata, err);
        apb_xfer(1'b0, reg_status, 32'd0, rdata, err);
        check_value("status.busy", 32'd1, 32'(rdata[0]));
        apb_xfer(1'b1, reg_ctrl, 32'h6, rdata, err);
        apb_xfer(1'b0, reg_status, 32'd0, rdata, err);
        check_value("status after zeroize", 32'd0, rdata);
        run_case(case_no + 2, 1, 0, -1, 32'd0, 0);

        // Reserved mode write is rejected and changes nothing
        apb_xfer(1'b0, reg_ctrl, 32'd0, ctrl_before, err);
        apb_xfer(1'b0, reg_status, 32'd0, status_before, err);
        apb_xfer(1'b1, reg_ctrl, 32'hD, rdata, err);
        check_value("pslverr", 32'd1, 32'(err));
        apb_xfer(1'b0, reg_ctrl, 32'd0, rdata, err);
        check_value("ctrl", ctrl_before, rdata);
        check_value("pslverr", 32'd0, 32'(err));
        apb_xfer(1'b0, reg_status, 32'd0, rdata, err);
        check_value("status", status_before, rdata);

        // Unmapped offset, read and write
        apb_xfer(1'b0, 4'hC, 32'd0, rdata, err);
        check_value("pslverr", 32'd1, 32'(err));
        apb_xfer(1'b1, 4'hC, 32'h1, rdata, err);
        check_value("pslverr", 32'd1, 32'(err));

        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/norm_check_input.txt
# mode (0 z_bound, 1 r0_bound, 2 ct0_bound), base word address (hex),
# injected coefficient index (-1 none), injected value (hex), expected violation
0 000 -1 0 0
1 000 -1 0 0
2 000 -1 0 0
0 000 1536 7FF87 0
0 000 1791 7FF88 1
0 000 1537 77E07A 0
0 000 1790 77E079 1
0 000 1800 7FF88 0
0 000 4 7FFFFF 1
1 000 1792 3FE87 0
1 000 2047 3FE88 1
1 000 1793 7BE17A 0
1 000 2046 7BE179 1
2 000 1795 3FEFF 0
2 000 2044 3FF00 1
2 000 1794 7BE102 0
2 000 2045 7BE101 1
1 0A3 300 3FEC4 1
2 0A3 300 3FEC4 0

// File: sim.f
source/norm_check_pkg.sv
source/coeff_rd_if.sv
source/norm_check_ctrl.sv
source/norm_check_unit.sv
source/coeff_mem.sv
source/norm_check_apb_regs.sv
source/norm_check_top.sv
tb/tb_norm_check.sv
